/* i3c_consts.svh */
// Shared constants of the I3C controller, included by the RTL and the testbench
`ifndef I3C_CONSTS_SVH
`define I3C_CONSTS_SVH

// Device Address Table size
`define I3C_DAT_DEPTH 8

// System clocks per SCL quarter period
`define I3C_SCL_DIV 4

// Host register byte offsets
`define I3C_REG_CMD    8'h00
`define I3C_REG_STATUS 8'h04
`define I3C_REG_RXDATA 8'h08

// STATUS bit positions
`define I3C_STAT_BUSY    0
`define I3C_STAT_DONE    1
`define I3C_STAT_NACK    2
`define I3C_STAT_ERR     3
`define I3C_STAT_OVERRUN 4

`endif

/* i3c_pkg.sv */
// Types shared by the I3C controller blocks: DAT entries, command words and responses
`include "i3c_consts.svh"

package i3c_pkg;

  // Index into the Device Address Table
  typedef logic [$clog2(`I3C_DAT_DEPTH)-1:0] dat_idx_t;

  typedef struct packed {
    logic       valid;
    logic [6:0] addr;   // Dynamic address
  } dat_entry_t;

  // Top bit of every command word
  typedef enum logic {
    CMD_XFER   = 1'b0,
    CMD_DAT_WR = 1'b1
  } cmd_attr_e;

  // Single-byte private transfer
  typedef struct packed {
    cmd_attr_e                    attr;
    dat_idx_t                     idx;
    logic                         rnw;
    logic [7:0]                   data;   // Write byte, ignored on reads
    logic [21-$bits(dat_idx_t):0] rsvd;
  } xfer_cmd_t;

  // Programs one DAT entry
  typedef struct packed {
    cmd_attr_e                    attr;
    dat_idx_t                     idx;
    dat_entry_t                   entry;
    logic [22-$bits(dat_idx_t):0] rsvd;
  } dat_wr_cmd_t;

  // One command word, attr selects the view
  typedef union packed {
    xfer_cmd_t   xfer;
    dat_wr_cmd_t dat_wr;
  } cmd_desc_u;

  typedef struct packed {
    logic       nack;
    logic       err;
    logic [7:0] data;   // Last received byte
  } i3c_rsp_t;

endpackage

/* i3c_dat.sv */
// Device Address Table: reset-cleared valid bits, address storage and a registered read port
`timescale 1ns/1ps
`include "i3c_consts.svh"

module i3c_dat (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                we_i,
  input  i3c_pkg::dat_idx_t   waddr_i,
  input  i3c_pkg::dat_entry_t wdata_i,
  input  logic                re_i,
  input  i3c_pkg::dat_idx_t   raddr_i,
  output i3c_pkg::dat_entry_t rdata_o
);

  logic [`I3C_DAT_DEPTH-1:0] valid_q;
  logic [6:0]                addr_mem [`I3C_DAT_DEPTH];

  // Entries start out invalid
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= '0;
    end else if (we_i) begin
      valid_q[waddr_i] <= wdata_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      addr_mem[waddr_i] <= wdata_i.addr;
    end
  end

  // Read data valid the cycle after re_i
  always_ff @(posedge clk_i) begin
    if (re_i) begin
      rdata_o.valid <= valid_q[raddr_i];
      rdata_o.addr  <= addr_mem[raddr_i];   // Old data on a same-cycle write
    end
  end

endmodule

/* i3c_scl_gen.sv */
// SCL divider: free-running quarter-period strobe, SCL level and mid-low/mid-high strobes
`timescale 1ns/1ps
`include "i3c_consts.svh"

module i3c_scl_gen (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic run_i,
  output logic scl_o,
  output logic quarter_tick_o,
  output logic drive_tick_o,
  output logic sample_tick_o
);

  localparam int unsigned CntW = $clog2(`I3C_SCL_DIV + 1);

  logic [CntW-1:0] div_q;
  logic [1:0]      phase_q;   // Quarters 0 and 1 low, 2 and 3 high

  assign quarter_tick_o = (div_q == CntW'(`I3C_SCL_DIV - 1));

  // Runs even while the bus is idle, for START and STOP timing
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      div_q <= '0;
    end else if (quarter_tick_o) begin
      div_q <= '0;
    end else begin
      div_q <= div_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      phase_q <= 2'd0;
    end else if (!run_i) begin
      phase_q <= 2'd0;   // Next run starts with SCL low
    end else if (quarter_tick_o) begin
      phase_q <= phase_q + 2'd1;
    end
  end

  assign scl_o         = ~run_i | phase_q[1];   // Parked high when stopped
  assign drive_tick_o  = run_i & quarter_tick_o & (phase_q == 2'd0);
  assign sample_tick_o = run_i & quarter_tick_o & (phase_q == 2'd2);

endmodule

/* i3c_csr.sv */
// Host register block: serves req/ack accesses, keeps status and hands commands to the controller
`timescale 1ns/1ps
`include "i3c_consts.svh"

module i3c_csr (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               host_req_i,
  input  logic               host_we_i,
  input  logic [7:0]         host_addr_i,
  input  logic [31:0]        host_wdata_i,
  output logic               host_ack_o,
  output logic [31:0]        host_rdata_o,
  output logic               cmd_req_o,
  output i3c_pkg::cmd_desc_u cmd_o,
  input  logic               cmd_ack_i,
  input  i3c_pkg::i3c_rsp_t  rsp_i,
  output logic               irq_o
);

  logic       req_q;      // Synchronizing stage of host_req_i
  logic       busy_q;
  logic       done_q;
  logic       nack_q;
  logic       err_q;
  logic       overrun_q;
  logic [7:0] rxdata_q;
  logic       access;
  logic       cmd_wr;
  logic       status_wr;
  logic       cmd_done;
  logic [4:0] status;

  assign access    = req_q & host_req_i & ~host_ack_o;
  assign cmd_wr    = access & host_we_i & (host_addr_i == `I3C_REG_CMD);
  assign status_wr = access & host_we_i & (host_addr_i == `I3C_REG_STATUS);
  assign cmd_done  = cmd_req_o & cmd_ack_i;

  always_comb begin
    status                      = '0;
    status[`I3C_STAT_BUSY]      = busy_q;
    status[`I3C_STAT_DONE]      = done_q;
    status[`I3C_STAT_NACK]      = nack_q;
    status[`I3C_STAT_ERR]       = err_q;
    status[`I3C_STAT_OVERRUN]   = overrun_q;
  end

  // Four-phase host handshake
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_q      <= 1'b0;
      host_ack_o <= 1'b0;
    end else begin
      req_q <= host_req_i;
      if (!host_req_i) begin
        host_ack_o <= 1'b0;
      end else if (access) begin
        host_ack_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access && !host_we_i) begin
      case (host_addr_i)
        `I3C_REG_STATUS: host_rdata_o <= {27'd0, status};
        `I3C_REG_RXDATA: host_rdata_o <= {24'd0, rxdata_q};
        default:         host_rdata_o <= '0;
      endcase
    end
  end

  // Status flags and the command channel
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cmd_req_o <= 1'b0;
      busy_q    <= 1'b0;
      done_q    <= 1'b0;
      nack_q    <= 1'b0;
      err_q     <= 1'b0;
      overrun_q <= 1'b0;
    end else begin
      if (status_wr) begin   // Any write clears the sticky bits
        done_q    <= 1'b0;
        nack_q    <= 1'b0;
        err_q     <= 1'b0;
        overrun_q <= 1'b0;
      end
      if (cmd_wr) begin
        if (busy_q) begin
          overrun_q <= 1'b1;   // Command dropped
        end else begin
          cmd_req_o <= 1'b1;
          busy_q    <= 1'b1;
        end
      end
      if (cmd_done) begin
        cmd_req_o <= 1'b0;
        done_q    <= 1'b1;
        nack_q    <= nack_q | rsp_i.nack;
        err_q     <= err_q | rsp_i.err;
      end else if (busy_q && !cmd_req_o && !cmd_ack_i) begin
        busy_q <= 1'b0;   // Controller has dropped ack
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_wr && !busy_q) begin
      cmd_o <= host_wdata_i;
    end
    if (cmd_done) begin
      rxdata_q <= rsp_i.data;
    end
  end

  assign irq_o = done_q;

  // Ack only after req has passed the synchronizer
  ack_after_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(host_ack_o) |-> $past(host_req_i) && $past(host_req_i, 2));

endmodule

/* i3c_sdr_ctrl.sv */
// SDR bus controller: runs DAT writes and single-byte private transfers on SCL/SDA
`timescale 1ns/1ps

module i3c_sdr_ctrl (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                cmd_req_i,
  input  i3c_pkg::cmd_desc_u  cmd_i,
  output logic                cmd_ack_o,
  output i3c_pkg::i3c_rsp_t   rsp_o,
  output logic                dat_we_o,
  output i3c_pkg::dat_idx_t   dat_waddr_o,
  output i3c_pkg::dat_entry_t dat_wdata_o,
  output logic                dat_re_o,
  output i3c_pkg::dat_idx_t   dat_raddr_o,
  input  i3c_pkg::dat_entry_t dat_rdata_i,
  output logic                scl_run_o,
  input  logic                quarter_tick_i,
  input  logic                drive_tick_i,
  input  logic                sample_tick_i,
  input  logic                sda_i,
  output logic                sda_o,
  output logic                sel_od_pp_o
);

  import i3c_pkg::*;

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_DECODE,
    ST_CHECK,
    ST_START,
    ST_ADDR,
    ST_ACK,
    ST_DATA,
    ST_TBIT,
    ST_STOP,
    ST_STOP_HOLD,
    ST_RESP
  } state_e;

  state_e     state_q;
  logic [2:0] bit_cnt_q;
  logic [7:0] addr_q;   // Dynamic address and RnW
  logic       nack_q;
  logic       err_q;
  logic [7:0] rx_q;
  logic       is_dat_wr;
  logic       rnw;

  // attr sits at the top of both views
  assign is_dat_wr = (cmd_i.xfer.attr == CMD_DAT_WR);
  assign rnw       = cmd_i.xfer.rnw;

  assign dat_we_o    = (state_q == ST_DECODE) & is_dat_wr;
  assign dat_waddr_o = cmd_i.dat_wr.idx;
  assign dat_wdata_o = cmd_i.dat_wr.entry;
  assign dat_re_o    = (state_q == ST_DECODE) & ~is_dat_wr;
  assign dat_raddr_o = cmd_i.xfer.idx;

  assign rsp_o = '{nack: nack_q, err: err_q, data: rx_q};

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= ST_IDLE;
      bit_cnt_q   <= '0;
      nack_q      <= 1'b0;
      err_q       <= 1'b0;
      cmd_ack_o   <= 1'b0;
      scl_run_o   <= 1'b0;
      sda_o       <= 1'b1;
      sel_od_pp_o <= 1'b0;
    end else begin
      unique case (state_q)
        ST_IDLE: begin
          if (cmd_req_i) begin
            state_q <= ST_DECODE;
          end
        end
        ST_DECODE: begin
          nack_q <= 1'b0;
          err_q  <= 1'b0;
          if (is_dat_wr) begin   // Entry written this cycle
            cmd_ack_o <= 1'b1;
            state_q   <= ST_RESP;
          end else begin
            state_q <= ST_CHECK;
          end
        end
        ST_CHECK: begin
          if (!dat_rdata_i.valid) begin
            err_q     <= 1'b1;   // No bus activity
            cmd_ack_o <= 1'b1;
            state_q   <= ST_RESP;
          end else begin
            state_q <= ST_START;
          end
        end
        ST_START: begin
          if (quarter_tick_i) begin
            if (sda_o) begin
              sda_o <= 1'b0;   // SDA falls while SCL is high
            end else begin
              scl_run_o <= 1'b1;
              bit_cnt_q <= 3'd7;
              state_q   <= ST_ADDR;
            end
          end
        end
        ST_ADDR: begin
          if (drive_tick_i) begin
            sda_o <= addr_q[bit_cnt_q];
          end
          if (sample_tick_i) begin
            if (bit_cnt_q == 3'd0) begin
              state_q <= ST_ACK;
            end else begin
              bit_cnt_q <= bit_cnt_q - 3'd1;
            end
          end
        end
        ST_ACK: begin
          if (drive_tick_i) begin
            sda_o <= 1'b1;   // Released for the target
          end
          if (sample_tick_i) begin
            bit_cnt_q <= 3'd7;
            if (sda_i) begin
              nack_q  <= 1'b1;
              state_q <= ST_STOP;
            end else begin
              state_q <= ST_DATA;
            end
          end
        end
        ST_DATA: begin
          if (drive_tick_i) begin
            sel_od_pp_o <= 1'b1;   // Push-pull from the first data bit
            sda_o       <= rnw | cmd_i.xfer.data[bit_cnt_q];
          end
          if (sample_tick_i) begin
            if (bit_cnt_q == 3'd0) begin
              state_q <= ST_TBIT;
            end else begin
              bit_cnt_q <= bit_cnt_q - 3'd1;
            end
          end
        end
        ST_TBIT: begin
          if (drive_tick_i) begin
            // Odd parity on writes, end of data on reads
            sda_o <= ~rnw & ~^cmd_i.xfer.data;
          end
          if (sample_tick_i) begin
            state_q <= ST_STOP;
          end
        end
        ST_STOP: begin
          if (drive_tick_i) begin
            sda_o <= 1'b0;
          end
          if (sample_tick_i) begin
            scl_run_o <= 1'b0;   // SCL stays high
            state_q   <= ST_STOP_HOLD;
          end
        end
        ST_STOP_HOLD: begin
          if (quarter_tick_i) begin
            sda_o       <= 1'b1;   // SDA rises, STOP
            sel_od_pp_o <= 1'b0;
            cmd_ack_o   <= 1'b1;
            state_q     <= ST_RESP;
          end
        end
        ST_RESP: begin
          if (!cmd_req_i) begin
            cmd_ack_o <= 1'b0;
            state_q   <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ST_CHECK) begin
      addr_q <= {dat_rdata_i.addr, rnw};
    end
    if (state_q == ST_DATA && sample_tick_i && rnw) begin
      rx_q <= {rx_q[6:0], sda_i};   // MSB first
    end
  end

  // Four-phase command channel, ack drops the cycle after req
  ack_within_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cmd_ack_o |-> cmd_req_i || $fell(cmd_req_i));

  // Address and ACK bits go out open-drain
  od_addr_phase: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    state_q inside {ST_START, ST_ADDR, ST_ACK} |-> !sel_od_pp_o);

endmodule

/* i3c_wrapper.sv */
// Top level of the reduced I3C controller with digital SCL/SDA pins and a req/ack host port
`timescale 1ns/1ps

module i3c_wrapper (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        host_req_i,
  input  logic        host_we_i,
  input  logic [7:0]  host_addr_i,
  input  logic [31:0] host_wdata_i,
  output logic        host_ack_o,
  output logic [31:0] host_rdata_o,
  input  logic        scl_i,   // SCL readback, no stretching or arbitration here
  input  logic        sda_i,
  output logic        scl_o,
  output logic        sda_o,
  output logic        sel_od_pp_o,
  output logic        irq_o
);

  import i3c_pkg::*;

  logic       cmd_req;
  cmd_desc_u  cmd;
  logic       cmd_ack;
  i3c_rsp_t   rsp;
  logic       dat_we;
  dat_idx_t   dat_waddr;
  dat_entry_t dat_wdata;
  logic       dat_re;
  dat_idx_t   dat_raddr;
  dat_entry_t dat_rdata;
  logic       scl_run;
  logic       quarter_tick;
  logic       drive_tick;
  logic       sample_tick;

  i3c_csr i3c_csr_inst (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .host_req_i   (host_req_i),
    .host_we_i    (host_we_i),
    .host_addr_i  (host_addr_i),
    .host_wdata_i (host_wdata_i),
    .host_ack_o   (host_ack_o),
    .host_rdata_o (host_rdata_o),
    .cmd_req_o    (cmd_req),
    .cmd_o        (cmd),
    .cmd_ack_i    (cmd_ack),
    .rsp_i        (rsp),
    .irq_o        (irq_o)
  );

  i3c_sdr_ctrl i3c_sdr_ctrl_inst (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .cmd_req_i      (cmd_req),
    .cmd_i          (cmd),
    .cmd_ack_o      (cmd_ack),
    .rsp_o          (rsp),
    .dat_we_o       (dat_we),
    .dat_waddr_o    (dat_waddr),
    .dat_wdata_o    (dat_wdata),
    .dat_re_o       (dat_re),
    .dat_raddr_o    (dat_raddr),
    .dat_rdata_i    (dat_rdata),
    .scl_run_o      (scl_run),
    .quarter_tick_i (quarter_tick),
    .drive_tick_i   (drive_tick),
    .sample_tick_i  (sample_tick),
    .sda_i          (sda_i),
    .sda_o          (sda_o),
    .sel_od_pp_o    (sel_od_pp_o)
  );

  i3c_scl_gen i3c_scl_gen_inst (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .run_i          (scl_run),
    .scl_o          (scl_o),
    .quarter_tick_o (quarter_tick),
    .drive_tick_o   (drive_tick),
    .sample_tick_o  (sample_tick)
  );

  // Stands in for the external DAT RAM
  i3c_dat i3c_dat_inst (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .we_i     (dat_we),
    .waddr_i  (dat_waddr),
    .wdata_i  (dat_wdata),
    .re_i     (dat_re),
    .raddr_i  (dat_raddr),
    .rdata_o  (dat_rdata)
  );

endmodule

/* i3c_target_model.sv */
// Testbench I3C target: acks one address, captures write bytes, returns a read byte, counts STARTs
`timescale 1ns/1ps

module i3c_target_model #(
  parameter logic [6:0] TargetAddr = 7'h2A
) (
  input  logic       scl_i,
  input  logic       sda_i,         // Resolved bus level
  input  logic       sel_od_pp_i,
  input  logic [7:0] rd_byte_i,
  output logic       sda_o,
  output int         start_cnt_o,
  output int         wr_cnt_o,
  output logic [7:0] wr_byte_o,
  output logic       tbit_ok_o,     // Parity of the last write was odd
  output logic       od_ok_o        // Last address phase ran open-drain
);

  logic       scl_q;
  logic       sda_q;
  int         bit_cnt;   // SCL rising edges since START
  logic [7:0] addr_sr;
  logic [7:0] data_sr;
  logic       selected;

  initial begin
    scl_q       = 1'b1;
    sda_q       = 1'b1;
    sda_o       = 1'b1;
    start_cnt_o = 0;
    wr_cnt_o    = 0;
    wr_byte_o   = '0;
    tbit_ok_o   = 1'b0;
    od_ok_o     = 1'b0;
    bit_cnt     = 0;
    selected    = 1'b0;
  end

  always @(scl_i or sda_i) begin
    if (scl_i === 1'b1 && scl_q === 1'b1) begin
      if (sda_q === 1'b1 && sda_i === 1'b0) begin   // START
        start_cnt_o = start_cnt_o + 1;
        bit_cnt     = 0;
        selected    = 1'b0;
        od_ok_o     = 1'b1;
      end else if (sda_q === 1'b0 && sda_i === 1'b1) begin   // STOP
        bit_cnt  = 0;
        selected = 1'b0;
        sda_o   <= 1'b1;
      end
    end else if (scl_q === 1'b0 && scl_i === 1'b1) begin
      bit_cnt = bit_cnt + 1;
      // Address and ACK bits must see open-drain mode
      if (bit_cnt <= 9 && sel_od_pp_i !== 1'b0) od_ok_o = 1'b0;
      if (bit_cnt <= 8) addr_sr = {addr_sr[6:0], sda_i};
      if (bit_cnt == 8) selected = (addr_sr[7:1] == TargetAddr);
      if (selected && !addr_sr[0] && bit_cnt >= 10 && bit_cnt <= 17) begin
        data_sr = {data_sr[6:0], sda_i};   // MSB first
      end
      if (selected && !addr_sr[0] && bit_cnt == 18) begin
        wr_cnt_o  = wr_cnt_o + 1;
        wr_byte_o = data_sr;
        tbit_ok_o = ^{data_sr, sda_i};
      end
    end else if (scl_q === 1'b1 && scl_i === 1'b0) begin
      // Next bit is bit_cnt + 1
      if (selected && bit_cnt == 8) begin
        sda_o <= 1'b0;   // ACK
      end else if (selected && addr_sr[0] && bit_cnt >= 9 && bit_cnt <= 16) begin
        sda_o <= rd_byte_i[16 - bit_cnt];
      end else begin
        sda_o <= 1'b1;
      end
    end
    scl_q = scl_i;
    sda_q = sda_i;
  end

endmodule

/* tb_i3c_wrapper.sv */
// Testbench for the I3C wrapper: host-port handshake tasks, a target model and directed tests
`timescale 1ns/1ps
`include "i3c_consts.svh"

module tb_i3c_wrapper;

  import i3c_pkg::*;

  localparam int unsigned WatchdogNs = 6 * 40 * `I3C_SCL_DIV * 100 * 2;
  localparam int          AckTimeout = 16;
  localparam int          IrqTimeout = 200 * `I3C_SCL_DIV;   // Cycles, about 200 quarters
  localparam logic [31:0] StDone     = 32'h1 << `I3C_STAT_DONE;
  localparam logic [31:0] StNack     = 32'h1 << `I3C_STAT_NACK;
  localparam logic [31:0] StErr      = 32'h1 << `I3C_STAT_ERR;
  localparam logic [31:0] StOverrun  = 32'h1 << `I3C_STAT_OVERRUN;

  logic        clk;
  logic        arst_n;
  logic        host_req;
  logic        host_we;
  logic [7:0]  host_addr;
  logic [31:0] host_wdata;
  logic        host_ack;
  logic [31:0] host_rdata;
  logic        scl;
  logic        dut_sda;
  logic        tgt_sda;
  logic        sda_bus;
  logic        sel_od_pp;
  logic        irq;
  logic [7:0]  tgt_rd_byte;
  int          start_cnt;
  int          wr_cnt;
  logic [7:0]  wr_byte;
  logic        tbit_ok;
  logic        od_ok;
  int          errors;
  int          tests_run;
  int          tests_failed;
  integer      seed;

  assign sda_bus = dut_sda & tgt_sda;   // Wired-AND bus

  i3c_wrapper i3c_wrapper_inst (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .host_req_i   (host_req),
    .host_we_i    (host_we),
    .host_addr_i  (host_addr),
    .host_wdata_i (host_wdata),
    .host_ack_o   (host_ack),
    .host_rdata_o (host_rdata),
    .scl_i        (scl),
    .sda_i        (sda_bus),
    .scl_o        (scl),
    .sda_o        (dut_sda),
    .sel_od_pp_o  (sel_od_pp),
    .irq_o        (irq)
  );

  i3c_target_model #(.TargetAddr(7'h2A)) i3c_target_model_inst (
    .scl_i       (scl),
    .sda_i       (sda_bus),
    .sel_od_pp_i (sel_od_pp),
    .rd_byte_i   (tgt_rd_byte),
    .sda_o       (tgt_sda),
    .start_cnt_o (start_cnt),
    .wr_cnt_o    (wr_cnt),
    .wr_byte_o   (wr_byte),
    .tbit_ok_o   (tbit_ok),
    .od_ok_o     (od_ok)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] xfer_word(input dat_idx_t idx, input logic rnw,
                                            input logic [7:0] data);
    xfer_cmd_t c;
    c      = '0;
    c.attr = CMD_XFER;
    c.idx  = idx;
    c.rnw  = rnw;
    c.data = data;
    return c;
  endfunction

  function automatic logic [31:0] dat_word(input dat_idx_t idx, input logic [6:0] addr);
    dat_wr_cmd_t c;
    c             = '0;
    c.attr        = CMD_DAT_WR;
    c.idx         = idx;
    c.entry.valid = 1'b1;
    c.entry.addr  = addr;
    return c;
  endfunction

  // One four-phase access, inputs change on the falling edge
  task automatic host_access(input logic we, input logic [7:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
    int n;
    @(negedge clk);
    host_req   = 1'b1;
    host_we    = we;
    host_addr  = addr;
    host_wdata = wdata;
    n = 0;
    while (!host_ack && n < AckTimeout) begin
      @(negedge clk);
      n++;
    end
    if (!host_ack) begin
      $display("ERROR at %0t: no ack from the host port for offset 0x%02h", $time, addr);
      errors++;
    end
    rdata    = host_rdata;
    host_req = 1'b0;
    n = 0;
    @(negedge clk);
    while (host_ack && n < AckTimeout) begin
      @(negedge clk);
      n++;
    end
    if (host_ack) begin
      $display("ERROR at %0t: host ack stayed high after req dropped", $time);
      errors++;
    end
  endtask

  task automatic host_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    host_access(1'b1, addr, data, unused);
  endtask

  task automatic host_read(input logic [7:0] addr, output logic [31:0] data);
    host_access(1'b0, addr, 32'h0, data);
  endtask

  task automatic wait_for_irq();
    int n;
    n = 0;
    while (!irq && n < IrqTimeout) begin
      @(negedge clk);
      n++;
    end
    if (!irq) begin
      $display("ERROR at %0t: no completion interrupt within %0d cycles", $time, IrqTimeout);
      errors++;
    end
  endtask

  // Issue, wait for done, read STATUS, then clear it
  task automatic run_command(input logic [31:0] word, output logic [31:0] status);
    host_write(`I3C_REG_CMD, word);
    wait_for_irq();
    host_read(`I3C_REG_STATUS, status);
    host_write(`I3C_REG_STATUS, 32'h0);
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d error(s)", name, errors - errors_before);
    end
  endtask

  task automatic reset_state();
    int          errs;
    logic [31:0] st;
    errs = errors;
    if (irq !== 1'b0 || scl !== 1'b1 || dut_sda !== 1'b1 || sel_od_pp !== 1'b0) begin
      $display("FAIL %0t: pins after reset irq=%b scl=%b sda=%b sel_od_pp=%b",
               $time, irq, scl, dut_sda, sel_od_pp);
      errors++;
    end
    host_read(`I3C_REG_STATUS, st);
    if (st !== 32'h0) begin
      $display("FAIL %0t: STATUS after reset 0x%08h, expected 0", $time, st);
      errors++;
    end
    report_test("reset_state", errs);
  endtask

  task automatic dat_and_write();
    int          errs;
    int          wr_before;
    logic [31:0] st;
    logic [7:0]  tx;
    errs = errors;
    tx   = 8'($random(seed));
    run_command(dat_word(3'd3, 7'h2A), st);
    if (st !== StDone) begin
      $display("FAIL %0t: STATUS after DAT write 0x%08h", $time, st);
      errors++;
    end
    wr_before = wr_cnt;
    run_command(xfer_word(3'd3, 1'b0, tx), st);
    if (st !== StDone) begin
      $display("FAIL %0t: STATUS after private write 0x%08h", $time, st);
      errors++;
    end
    if (wr_cnt != wr_before + 1 || wr_byte !== tx) begin
      $display("FAIL %0t: target got %0d write(s), byte 0x%02h, expected 0x%02h",
               $time, wr_cnt - wr_before, wr_byte, tx);
      errors++;
    end
    if (!tbit_ok) begin
      $display("FAIL %0t: T-bit does not give odd parity", $time);
      errors++;
    end
    if (!od_ok) begin
      $display("FAIL %0t: sel_od_pp high during the address phase", $time);
      errors++;
    end
    report_test("dat_and_write", errs);
  endtask

  task automatic private_read();
    int          errs;
    logic [31:0] st;
    logic [7:0]  rx;
    errs        = errors;
    rx          = 8'($random(seed));
    tgt_rd_byte = rx;
    run_command(xfer_word(3'd3, 1'b1, 8'h00), st);
    if (st !== StDone) begin
      $display("FAIL %0t: STATUS after private read 0x%08h", $time, st);
      errors++;
    end
    host_read(`I3C_REG_RXDATA, st);
    if (st !== {24'd0, rx}) begin
      $display("FAIL %0t: RXDATA 0x%08h, expected 0x%02h", $time, st, rx);
      errors++;
    end
    report_test("private_read", errs);
  endtask

  task automatic address_nack();
    int          errs;
    int          wr_before;
    logic [31:0] st;
    errs = errors;
    run_command(dat_word(3'd5, 7'h11), st);
    wr_before = wr_cnt;
    run_command(xfer_word(3'd5, 1'b0, 8'($random(seed))), st);
    if (st !== (StDone | StNack)) begin
      $display("FAIL %0t: STATUS after NACK 0x%08h", $time, st);
      errors++;
    end
    if (wr_cnt != wr_before) begin
      $display("FAIL %0t: target captured a byte from an unknown address", $time);
      errors++;
    end
    report_test("address_nack", errs);
  endtask

  task automatic invalid_entry();
    int          errs;
    int          starts_before;
    logic [31:0] st;
    errs          = errors;
    starts_before = start_cnt;
    run_command(xfer_word(3'd6, 1'b0, 8'h5A), st);
    if (st !== (StDone | StErr)) begin
      $display("FAIL %0t: STATUS after invalid entry 0x%08h", $time, st);
      errors++;
    end
    if (start_cnt != starts_before) begin
      $display("FAIL %0t: bus START on an invalid DAT entry", $time);
      errors++;
    end
    report_test("invalid_entry", errs);
  endtask

  task automatic overrun_and_clear();
    int          errs;
    int          wr_before;
    int          starts_before;
    logic [31:0] st;
    logic [7:0]  first;
    errs          = errors;
    first         = 8'($random(seed));
    wr_before     = wr_cnt;
    starts_before = start_cnt;
    host_write(`I3C_REG_CMD, xfer_word(3'd3, 1'b0, first));
    host_write(`I3C_REG_CMD, xfer_word(3'd3, 1'b0, ~first));   // Lands while busy
    wait_for_irq();
    host_read(`I3C_REG_STATUS, st);
    if (st !== (StDone | StOverrun)) begin
      $display("FAIL %0t: STATUS after overrun 0x%08h", $time, st);
      errors++;
    end
    if (wr_cnt != wr_before + 1 || start_cnt != starts_before + 1 || wr_byte !== first) begin
      $display("FAIL %0t: target saw %0d START(s), %0d write(s), last byte 0x%02h",
               $time, start_cnt - starts_before, wr_cnt - wr_before, wr_byte);
      errors++;
    end
    host_write(`I3C_REG_STATUS, 32'h0);
    host_read(`I3C_REG_STATUS, st);
    if (st !== 32'h0 || irq !== 1'b0) begin
      $display("FAIL %0t: STATUS 0x%08h irq=%b after clear", $time, st, irq);
      errors++;
    end
    report_test("overrun_and_clear", errs);
  endtask

  initial begin
    clk          = 1'b0;
    arst_n       = 1'b0;
    host_req     = 1'b0;
    host_we      = 1'b0;
    host_addr    = '0;
    host_wdata   = '0;
    tgt_rd_byte  = '0;
    seed         = 9854;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (16) @(negedge clk);
    arst_n = 1'b1;
    reset_state();
    dat_and_write();
    private_read();
    address_nack();
    invalid_entry();
    overrun_and_clear();
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Budget from six transfers at the configured SCL rate, doubled
  initial begin
    #(WatchdogNs);
    $display("Watchdog expired after %0d ns, the tests did not finish", WatchdogNs);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* i3c_wrapper.f */
+incdir+.
i3c_pkg.sv
i3c_dat.sv
i3c_scl_gen.sv
i3c_csr.sv
i3c_sdr_ctrl.sv
i3c_wrapper.sv
i3c_target_model.sv
tb_i3c_wrapper.sv

/* Bender.yml */
package:
  name: i3c_wrapper

export_include_dirs:
  - .

sources:
  - i3c_pkg.sv
  - i3c_dat.sv
  - i3c_scl_gen.sv
  - i3c_csr.sv
  - i3c_sdr_ctrl.sv
  - i3c_wrapper.sv
  - target: test
    files:
      - i3c_target_model.sv
      - tb_i3c_wrapper.sv
